//--- mips_config.svh
`ifndef MIPS_CONFIG_SVH
`define MIPS_CONFIG_SVH

// Datapath and address width
`define MIPS_DATA_W 32

// Register address width, 32 registers
`define MIPS_REG_W 5

// Memory depths in words
`define MIPS_IMEM_DEPTH 64
`define MIPS_DMEM_DEPTH 32

`endif

//--- mips_pkg.sv
`include "mips_config.svh"

package mips_pkg;

  typedef enum logic [5:0] {
    OP_SPECIAL = 6'h00,
    OP_ADDIU   = 6'h09,
    OP_LW      = 6'h23,
    OP_SW      = 6'h2b,
    OP_BEQ     = 6'h04,
    OP_HALT    = 6'h3f
  } opcode_e;

  // R-type function field
  typedef enum logic [5:0] {
    FN_ADDU = 6'h21,
    FN_SUBU = 6'h23,
    FN_AND  = 6'h24,
    FN_OR   = 6'h25,
    FN_SLT  = 6'h2a
  } funct_e;

  typedef enum logic [2:0] {
    ALU_ADD = 3'd0,
    ALU_SUB = 3'd1,
    ALU_AND = 3'd2,
    ALU_OR  = 3'd3,
    ALU_SLT = 3'd4
  } alu_op_e;

  typedef struct packed {
    logic                    valid;
    logic [`MIPS_DATA_W-1:0] pc4;
    logic [`MIPS_DATA_W-1:0] instruction;
  } if_id_t;

  typedef struct packed {
    logic                    valid;
    logic [`MIPS_DATA_W-1:0] pc4;
    logic [`MIPS_DATA_W-1:0] data_a;
    logic [`MIPS_DATA_W-1:0] data_b;
    logic [`MIPS_DATA_W-1:0] imm;     // Sign extended
    logic [`MIPS_REG_W-1:0]  rs;
    logic [`MIPS_REG_W-1:0]  rt;
    logic [`MIPS_REG_W-1:0]  rd;      // Destination, rt or rd field
    alu_op_e                 alu_op;
    logic                    alu_src; // Immediate as operand b
    logic                    mem_read;
    logic                    mem_write;
    logic                    reg_write;
    logic                    branch;
    logic                    halt;
  } id_ex_t;

  typedef struct packed {
    logic                    valid;
    logic [`MIPS_DATA_W-1:0] alu_result;
    logic [`MIPS_DATA_W-1:0] store_data;
    logic [`MIPS_REG_W-1:0]  rd;
    logic                    mem_read;
    logic                    mem_write;
    logic                    reg_write;
    logic                    halt;
  } ex_mem_t;

  typedef struct packed {
    logic                    valid;
    logic [`MIPS_REG_W-1:0]  rd;
    logic [`MIPS_DATA_W-1:0] wb_data;
    logic                    reg_write;
    logic                    halt;
  } mem_wb_t;

  // Writeback bus, also the late forwarding source
  typedef struct packed {
    logic                    write;
    logic [`MIPS_REG_W-1:0]  rd;
    logic [`MIPS_DATA_W-1:0] data;
  } wb_t;

endpackage

//--- mips_fetch.sv
`include "mips_config.svh"

module mips_fetch (
  input  logic                    i_clk,
  input  logic                    i_rst_n,
  input  logic                    i_step,
  input  logic                    i_stall,
  input  logic                    i_halt_seen,
  input  logic                    i_branch_taken,
  input  logic [`MIPS_DATA_W-1:0] i_branch_target,
  input  logic                    i_imem_we,
  input  logic [`MIPS_DATA_W-1:0] i_imem_addr,
  input  logic [`MIPS_DATA_W-1:0] i_imem_data,
  output mips_pkg::if_id_t        o_if_id,
  output logic [`MIPS_DATA_W-1:0] o_pc
);
  import mips_pkg::*;

  localparam int IMEM_AW = $clog2(`MIPS_IMEM_DEPTH);

  logic [`MIPS_DATA_W-1:0] imem [0:`MIPS_IMEM_DEPTH-1];
  logic [`MIPS_DATA_W-1:0] pc4;

  assign pc4 = o_pc + `MIPS_DATA_W'(4);

  // Load port, byte addressed, ignores i_step
  always_ff @(posedge i_clk) begin
    if (i_imem_we) begin
      imem[i_imem_addr[IMEM_AW+1:2]] <= i_imem_data;
    end
  end

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_pc    <= '0;
      o_if_id <= '0;
    end else if (i_step) begin
      if (i_branch_taken) begin
        o_pc <= i_branch_target; // Branch wins over stall
      end else if (!i_stall && !i_halt_seen) begin
        o_pc <= pc4;
      end
      if (i_branch_taken || i_halt_seen) begin
        o_if_id <= '0;
      end else if (!i_stall) begin
        o_if_id.valid       <= 1'b1;
        o_if_id.pc4         <= pc4;
        o_if_id.instruction <= imem[o_pc[IMEM_AW+1:2]];
      end
    end
  end

  a_pc_aligned: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    o_pc[1:0] == 2'b00);

endmodule

//--- mips_decode.sv
`include "mips_config.svh"

module mips_decode (
  input  logic                    i_clk,
  input  logic                    i_rst_n,
  input  logic                    i_step,
  input  mips_pkg::if_id_t        i_if_id,
  input  mips_pkg::wb_t           i_wb,
  input  logic                    i_branch_taken,
  input  logic [`MIPS_REG_W-1:0]  i_dbg_reg,
  output mips_pkg::id_ex_t        o_id_ex,
  output logic                    o_stall,
  output logic                    o_halt_seen,
  output logic [`MIPS_DATA_W-1:0] o_dbg_reg_data
);
  import mips_pkg::*;

  logic [`MIPS_DATA_W-1:0] regs [0:(1<<`MIPS_REG_W)-1];
  logic [`MIPS_REG_W-1:0]  rs;
  logic [`MIPS_REG_W-1:0]  rt;
  logic [`MIPS_DATA_W-1:0] rs_data;
  logic [`MIPS_DATA_W-1:0] rt_data;
  id_ex_t                  id_ex_d;
  logic                    uses_rt;
  logic                    halt_q;
  logic                    halt_now;

  assign rs = i_if_id.instruction[25:21];
  assign rt = i_if_id.instruction[20:16];

  always_ff @(posedge i_clk) begin
    if (i_step && i_wb.write && i_wb.rd != '0) begin
      regs[i_wb.rd] <= i_wb.data;
    end
  end

  // Write-first reads, r0 is hardwired to zero
  assign rs_data = (rs == '0) ? '0 : (i_wb.write && i_wb.rd == rs) ? i_wb.data : regs[rs];
  assign rt_data = (rt == '0) ? '0 : (i_wb.write && i_wb.rd == rt) ? i_wb.data : regs[rt];
  assign o_dbg_reg_data = (i_dbg_reg == '0) ? '0 : regs[i_dbg_reg];

  always_comb begin
    id_ex_d        = '0;
    id_ex_d.valid  = 1'b1;
    id_ex_d.pc4    = i_if_id.pc4;
    id_ex_d.data_a = rs_data;
    id_ex_d.data_b = rt_data;
    id_ex_d.imm    = {{(`MIPS_DATA_W-16){i_if_id.instruction[15]}}, i_if_id.instruction[15:0]};
    id_ex_d.rs     = rs;
    id_ex_d.rt     = rt;
    id_ex_d.rd     = rt;
    id_ex_d.alu_op = ALU_ADD;
    uses_rt        = 1'b0;
    case (opcode_e'(i_if_id.instruction[31:26]))
      OP_SPECIAL: begin
        id_ex_d.rd        = i_if_id.instruction[15:11];
        id_ex_d.reg_write = 1'b1;
        uses_rt           = 1'b1;
        case (funct_e'(i_if_id.instruction[5:0]))
          FN_ADDU: id_ex_d.alu_op = ALU_ADD;
          FN_SUBU: id_ex_d.alu_op = ALU_SUB;
          FN_AND:  id_ex_d.alu_op = ALU_AND;
          FN_OR:   id_ex_d.alu_op = ALU_OR;
          FN_SLT:  id_ex_d.alu_op = ALU_SLT;
          default: id_ex_d.reg_write = 1'b0; // Unknown funct runs as nop
        endcase
      end
      OP_ADDIU: begin
        id_ex_d.alu_src   = 1'b1;
        id_ex_d.reg_write = 1'b1;
      end
      OP_LW: begin
        id_ex_d.alu_src   = 1'b1;
        id_ex_d.mem_read  = 1'b1;
        id_ex_d.reg_write = 1'b1;
      end
      OP_SW: begin
        id_ex_d.alu_src   = 1'b1;
        id_ex_d.mem_write = 1'b1;
        uses_rt           = 1'b1; // Store data
      end
      OP_BEQ: begin
        id_ex_d.branch = 1'b1;
        id_ex_d.alu_op = ALU_SUB;
        uses_rt        = 1'b1;
      end
      OP_HALT: id_ex_d.halt = 1'b1;
      default: ;
    endcase
  end

  // Load in ID/EX feeding the instruction in decode
  assign o_stall = i_if_id.valid && o_id_ex.mem_read && (o_id_ex.rd != '0) &&
                   ((o_id_ex.rd == rs) || (uses_rt && o_id_ex.rd == rt));

  assign halt_now    = i_if_id.valid && id_ex_d.halt && !o_stall && !i_branch_taken && !halt_q;
  assign o_halt_seen = halt_q || halt_now;

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      halt_q  <= 1'b0;
      o_id_ex <= '0;
    end else if (i_step) begin
      if (halt_now) begin
        halt_q <= 1'b1;
      end
      if (o_stall || i_branch_taken || halt_q || !i_if_id.valid) begin
        o_id_ex <= '0; // Bubble
      end else begin
        o_id_ex <= id_ex_d;
      end
    end
  end

  a_stall_needs_load: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    o_stall |-> o_id_ex.valid);

endmodule

//--- mips_execute.sv
`include "mips_config.svh"

module mips_execute (
  input  logic                    i_clk,
  input  logic                    i_rst_n,
  input  logic                    i_step,
  input  mips_pkg::id_ex_t        i_id_ex,
  input  mips_pkg::wb_t           i_wb,
  output mips_pkg::ex_mem_t       o_ex_mem,
  output logic                    o_branch_taken,
  output logic [`MIPS_DATA_W-1:0] o_branch_target,
  output logic [`MIPS_DATA_W-1:0] o_alu_result
);
  import mips_pkg::*;

  logic                    mem_fwd_ok;
  logic                    wb_fwd_ok;
  logic [`MIPS_DATA_W-1:0] op_a;
  logic [`MIPS_DATA_W-1:0] op_b;
  logic [`MIPS_DATA_W-1:0] alu_b;

  // A load still in EX/MEM has no data yet, the stall covers it
  assign mem_fwd_ok = o_ex_mem.valid && o_ex_mem.reg_write && !o_ex_mem.mem_read &&
                      (o_ex_mem.rd != '0);
  assign wb_fwd_ok  = i_wb.write && (i_wb.rd != '0);

  assign op_a = (mem_fwd_ok && o_ex_mem.rd == i_id_ex.rs) ? o_ex_mem.alu_result :
                (wb_fwd_ok && i_wb.rd == i_id_ex.rs)      ? i_wb.data : i_id_ex.data_a;
  assign op_b = (mem_fwd_ok && o_ex_mem.rd == i_id_ex.rt) ? o_ex_mem.alu_result :
                (wb_fwd_ok && i_wb.rd == i_id_ex.rt)      ? i_wb.data : i_id_ex.data_b;

  assign alu_b = i_id_ex.alu_src ? i_id_ex.imm : op_b;

  always_comb begin
    case (i_id_ex.alu_op)
      ALU_ADD: o_alu_result = op_a + alu_b;
      ALU_SUB: o_alu_result = op_a - alu_b;
      ALU_AND: o_alu_result = op_a & alu_b;
      ALU_OR:  o_alu_result = op_a | alu_b;
      ALU_SLT: o_alu_result = {{(`MIPS_DATA_W-1){1'b0}}, ($signed(op_a) < $signed(alu_b))};
      default: o_alu_result = '0;
    endcase
  end

  // Bubbles carry branch = 0
  assign o_branch_taken  = i_id_ex.branch && (op_a == op_b);
  assign o_branch_target = i_id_ex.pc4 + {i_id_ex.imm[`MIPS_DATA_W-3:0], 2'b00};

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_ex_mem <= '0;
    end else if (i_step) begin
      o_ex_mem.valid      <= i_id_ex.valid;
      o_ex_mem.alu_result <= o_alu_result;
      o_ex_mem.store_data <= op_b;
      o_ex_mem.rd         <= i_id_ex.rd;
      o_ex_mem.mem_read   <= i_id_ex.mem_read;
      o_ex_mem.mem_write  <= i_id_ex.mem_write;
      o_ex_mem.reg_write  <= i_id_ex.reg_write;
      o_ex_mem.halt       <= i_id_ex.halt;
    end
  end

  a_branch_from_valid: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    o_branch_taken |-> i_id_ex.valid);

endmodule

//--- mips_result.sv
`include "mips_config.svh"

module mips_result (
  input  logic                    i_clk,
  input  logic                    i_rst_n,
  input  logic                    i_step,
  input  mips_pkg::ex_mem_t       i_ex_mem,
  input  logic [`MIPS_DATA_W-1:0] i_dbg_addr,
  output mips_pkg::wb_t           o_wb,
  output logic [`MIPS_DATA_W-1:0] o_dbg_mem_data,
  output logic                    o_halt
);
  import mips_pkg::*;

  localparam int DMEM_AW = $clog2(`MIPS_DMEM_DEPTH);

  logic [`MIPS_DATA_W-1:0] dmem [0:`MIPS_DMEM_DEPTH-1];
  logic [DMEM_AW-1:0]      dmem_idx;
  mem_wb_t                 mem_wb_d;
  mem_wb_t                 mem_wb;

  assign dmem_idx = i_ex_mem.alu_result[DMEM_AW+1:2]; // Word index

  always_ff @(posedge i_clk) begin
    if (i_step && i_ex_mem.valid && i_ex_mem.mem_write) begin
      dmem[dmem_idx] <= i_ex_mem.store_data;
    end
  end

  assign o_dbg_mem_data = dmem[i_dbg_addr[DMEM_AW+1:2]];

  always_comb begin
    mem_wb_d.valid     = i_ex_mem.valid;
    mem_wb_d.rd        = i_ex_mem.rd;
    mem_wb_d.wb_data   = i_ex_mem.mem_read ? dmem[dmem_idx] : i_ex_mem.alu_result;
    mem_wb_d.reg_write = i_ex_mem.reg_write;
    mem_wb_d.halt      = i_ex_mem.halt;
  end

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      mem_wb <= '0;
      o_halt <= 1'b0;
    end else if (i_step) begin
      mem_wb <= mem_wb_d;
      if (mem_wb_d.valid && mem_wb_d.halt) begin
        o_halt <= 1'b1; // Sticky until reset
      end
    end
  end

  assign o_wb.write = mem_wb.valid && mem_wb.reg_write;
  assign o_wb.rd    = mem_wb.rd;
  assign o_wb.data  = mem_wb.wb_data;

endmodule

//--- mips_pipeline.sv
`include "mips_config.svh"

module mips_pipeline (
  input  logic                    i_clk,
  input  logic                    i_rst_n,
  input  logic                    i_step,
  input  logic                    i_imem_we,
  input  logic [`MIPS_DATA_W-1:0] i_imem_addr,
  input  logic [`MIPS_DATA_W-1:0] i_imem_data,
  input  logic [`MIPS_REG_W-1:0]  i_dbg_reg,
  input  logic [`MIPS_DATA_W-1:0] i_dbg_addr,
  output logic [`MIPS_DATA_W-1:0] o_pc,
  output logic [`MIPS_DATA_W-1:0] o_alu_result,
  output logic [`MIPS_DATA_W-1:0] o_dbg_reg_data,
  output logic [`MIPS_DATA_W-1:0] o_dbg_mem_data,
  output logic                    o_halt
);
  import mips_pkg::*;

  if_id_t                  if_id;
  id_ex_t                  id_ex;
  ex_mem_t                 ex_mem;
  wb_t                     wb;
  logic                    stall;
  logic                    halt_seen;
  logic                    branch_taken;
  logic [`MIPS_DATA_W-1:0] branch_target;

  mips_fetch u_fetch (
    .i_clk           (i_clk),
    .i_rst_n         (i_rst_n),
    .i_step          (i_step),
    .i_stall         (stall),
    .i_halt_seen     (halt_seen),
    .i_branch_taken  (branch_taken),
    .i_branch_target (branch_target),
    .i_imem_we       (i_imem_we),
    .i_imem_addr     (i_imem_addr),
    .i_imem_data     (i_imem_data),
    .o_if_id         (if_id),
    .o_pc            (o_pc)
  );

  mips_decode u_decode (
    .i_clk          (i_clk),
    .i_rst_n        (i_rst_n),
    .i_step         (i_step),
    .i_if_id        (if_id),
    .i_wb           (wb),
    .i_branch_taken (branch_taken),
    .i_dbg_reg      (i_dbg_reg),
    .o_id_ex        (id_ex),
    .o_stall        (stall),
    .o_halt_seen    (halt_seen),
    .o_dbg_reg_data (o_dbg_reg_data)
  );

  mips_execute u_execute (
    .i_clk           (i_clk),
    .i_rst_n         (i_rst_n),
    .i_step          (i_step),
    .i_id_ex         (id_ex),
    .i_wb            (wb),
    .o_ex_mem        (ex_mem),
    .o_branch_taken  (branch_taken),
    .o_branch_target (branch_target),
    .o_alu_result    (o_alu_result)
  );

  mips_result u_result (
    .i_clk          (i_clk),
    .i_rst_n        (i_rst_n),
    .i_step         (i_step),
    .i_ex_mem       (ex_mem),
    .i_dbg_addr     (i_dbg_addr),
    .o_wb           (wb),
    .o_dbg_mem_data (o_dbg_mem_data),
    .o_halt         (o_halt)
  );

endmodule

//--- mips_pipeline_tb.sv
`include "mips_config.svh"

module mips_pipeline_tb;
  import mips_pkg::*;

  localparam int PROG_MAX = `MIPS_IMEM_DEPTH;
  localparam int DMEM_WORDS = `MIPS_DMEM_DEPTH;
  localparam logic [31:0] HALT_WORD = 32'hfc00_0000; // Opcode 6'h3f

  logic                    i_clk;
  logic                    i_rst_n;
  logic                    i_step;
  logic                    i_imem_we;
  logic [`MIPS_DATA_W-1:0] i_imem_addr;
  logic [`MIPS_DATA_W-1:0] i_imem_data;
  logic [`MIPS_REG_W-1:0]  i_dbg_reg;
  logic [`MIPS_DATA_W-1:0] i_dbg_addr;
  logic [`MIPS_DATA_W-1:0] o_pc;
  logic [`MIPS_DATA_W-1:0] o_alu_result;
  logic [`MIPS_DATA_W-1:0] o_dbg_reg_data;
  logic [`MIPS_DATA_W-1:0] o_dbg_mem_data;
  logic                    o_halt;

  integer      seed = 27;
  int          error_count;
  int          check_count;
  bit          timed_out;
  logic [31:0] prog [0:PROG_MAX-1];
  int          prog_len;
  logic [31:0] exp_regs [0:31];
  logic [31:0] exp_mem [0:DMEM_WORDS-1];
  logic [31:0] exp_alu [0:6]; // ALU results of the setup ADDIUs
  bit          mem_written [0:DMEM_WORDS-1];
  bit          stored [0:DMEM_WORDS-1]; // Words the generator has stored so far

  mips_pipeline u_mips_pipeline (
    .i_clk          (i_clk),
    .i_rst_n        (i_rst_n),
    .i_step         (i_step),
    .i_imem_we      (i_imem_we),
    .i_imem_addr    (i_imem_addr),
    .i_imem_data    (i_imem_data),
    .i_dbg_reg      (i_dbg_reg),
    .i_dbg_addr     (i_dbg_addr),
    .o_pc           (o_pc),
    .o_alu_result   (o_alu_result),
    .o_dbg_reg_data (o_dbg_reg_data),
    .o_dbg_mem_data (o_dbg_mem_data),
    .o_halt         (o_halt)
  );

  initial begin
    i_clk = 1'b0;
    forever #10 i_clk = ~i_clk;
  end

  function automatic int rand_below(input int n);
    return $unsigned($random(seed)) % n;
  endfunction

  function automatic int rand_reg();
    return 1 + rand_below(7); // r1 to r7 only
  endfunction

  function automatic logic [31:0] encode_r(input logic [5:0] fn, input int rs, input int rt,
                                           input int rd);
    return {6'h00, 5'(rs), 5'(rt), 5'(rd), 5'h00, fn};
  endfunction

  function automatic logic [31:0] encode_i(input logic [5:0] op, input int rs, input int rt,
                                           input logic [15:0] imm);
    return {op, 5'(rs), 5'(rt), imm};
  endfunction

  task automatic emit(input logic [31:0] word);
    prog[prog_len] = word;
    prog_len++;
  endtask

  // Every used register gets a known value first
  task automatic start_program();
    prog_len = 0;
    foreach (stored[i]) stored[i] = 1'b0;
    for (int r = 1; r < 8; r++) begin
      emit(encode_i(OP_ADDIU, 0, r, 16'($random(seed))));
    end
  endtask

  task automatic emit_random_alu();
    case (rand_below(6))
      0: emit(encode_r(FN_ADDU, rand_reg(), rand_reg(), rand_reg()));
      1: emit(encode_r(FN_SUBU, rand_reg(), rand_reg(), rand_reg()));
      2: emit(encode_r(FN_AND, rand_reg(), rand_reg(), rand_reg()));
      3: emit(encode_r(FN_OR, rand_reg(), rand_reg(), rand_reg()));
      4: emit(encode_r(FN_SLT, rand_reg(), rand_reg(), rand_reg()));
      default: emit(encode_i(OP_ADDIU, rand_reg(), rand_reg(), 16'($random(seed))));
    endcase
  endtask

  task automatic build_alu_program(input int body);
    start_program();
    repeat (body) emit_random_alu();
    emit(HALT_WORD);
  endtask

  task automatic build_mem_program(input int body);
    int addr;
    int base;
    int rt;
    start_program();
    while (prog_len < 7 + body) begin
      addr = rand_below(DMEM_WORDS);
      base = rand_reg();
      rt   = rand_reg();
      case (rand_below(3))
        0: emit_random_alu();
        1: begin
          emit(encode_i(OP_ADDIU, 0, base, 16'(addr * 4)));
          emit(encode_i(OP_SW, base, rt, 16'h0000));
          stored[addr] = 1'b1;
        end
        default: begin
          emit(encode_i(OP_ADDIU, 0, base, 16'(addr * 4)));
          if (!stored[addr]) begin
            emit(encode_i(OP_SW, base, rt, 16'h0000)); // Never load an unwritten word
            stored[addr] = 1'b1;
          end
          emit(encode_i(OP_LW, base, rt, 16'h0000));
          emit(encode_r(FN_ADDU, rt, rand_reg(), rand_reg())); // Load-use
        end
      endcase
    end
    emit(HALT_WORD);
  endtask

  task automatic build_branch_program(input int blocks);
    int          rs;
    int          rt;
    int          skip;
    logic [15:0] a;
    logic [15:0] b;
    start_program();
    repeat (blocks) begin
      rs   = rand_reg();
      rt   = rs % 7 + 1;
      a    = 16'($random(seed));
      b    = (rand_below(2) == 0) ? a : a + 16'(1 + rand_below(1000));
      skip = 1 + rand_below(3);
      emit(encode_i(OP_ADDIU, 0, rs, a));
      emit(encode_i(OP_ADDIU, 0, rt, b));
      emit(encode_i(OP_BEQ, rs, rt, 16'(skip)));
      repeat (skip + 1) emit(encode_i(OP_ADDIU, 0, rand_reg(), 16'($random(seed))));
    end
    emit(HALT_WORD);
  endtask

  // Sequential instruction-set interpreter
  task automatic run_model();
    int          pc;
    int          steps;
    int          idx;
    logic [31:0] ins;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm;
    for (int r = 0; r < 32; r++) exp_regs[r] = '0;
    foreach (exp_mem[i]) begin
      exp_mem[i]     = '0;
      mem_written[i] = 1'b0;
    end
    pc    = 0;
    steps = 0;
    ins   = prog[0];
    while (ins[31:26] != OP_HALT && steps < 200) begin
      a   = exp_regs[ins[25:21]];
      b   = exp_regs[ins[20:16]];
      imm = {{16{ins[15]}}, ins[15:0]};
      idx = int'(((a + imm) >> 2) % DMEM_WORDS);
      pc  = pc + 1;
      case (ins[31:26])
        OP_SPECIAL: begin
          case (ins[5:0])
            FN_ADDU: exp_regs[ins[15:11]] = a + b;
            FN_SUBU: exp_regs[ins[15:11]] = a - b;
            FN_AND:  exp_regs[ins[15:11]] = a & b;
            FN_OR:   exp_regs[ins[15:11]] = a | b;
            FN_SLT:  exp_regs[ins[15:11]] = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            default: ;
          endcase
        end
        OP_ADDIU: begin
          exp_regs[ins[20:16]] = a + imm;
          if (steps < 7) begin
            exp_alu[steps] = a + imm;
          end
        end
        OP_LW:    exp_regs[ins[20:16]] = exp_mem[idx];
        OP_SW: begin
          exp_mem[idx]     = b;
          mem_written[idx] = 1'b1;
        end
        OP_BEQ: if (a == b) pc = pc + $signed(imm);
        default: ;
      endcase
      exp_regs[0] = '0;
      steps++;
      ins = prog[pc];
    end
  endtask

  task automatic load_program();
    @(posedge i_clk);
    i_step <= 1'b0;
    for (int a = 0; a < PROG_MAX; a++) begin
      @(posedge i_clk);
      i_imem_we   <= 1'b1;
      i_imem_addr <= 32'(a * 4);
      i_imem_data <= (a < prog_len) ? prog[a] : (HALT_WORD | 32'(a)); // HALT carrying its address
    end
    @(posedge i_clk);
    i_imem_we <= 1'b0;
  endtask

  task automatic apply_reset();
    @(posedge i_clk);
    i_rst_n <= 1'b0;
    repeat (3) @(posedge i_clk);
    i_rst_n <= 1'b1;
    @(negedge i_clk);
    check_count++;
    if (o_halt !== 1'b0 || o_pc !== '0) begin
      error_count++;
      $display("Error at %0t: after reset o_halt=%b o_pc=%h", $time, o_halt, o_pc);
    end
  endtask

  task automatic run_program(input bit random_step);
    int          cycles;
    int          low_cycles;
    bit          step_used;
    logic [31:0] pc_prev;
    cycles     = 0;
    low_cycles = 0;
    @(negedge i_clk);
    pc_prev = o_pc;
    while (!o_halt && !timed_out) begin
      @(posedge i_clk);
      step_used = i_step; // Value the DUT sees at this edge
      i_step <= random_step ? (rand_below(3) != 0) : 1'b1;
      @(negedge i_clk);
      cycles++;
      if (!step_used) begin
        low_cycles++;
        check_count++;
        if (o_pc !== pc_prev) begin
          error_count++;
          $display("Error at %0t: o_pc moved to %h while i_step was low", $time, o_pc);
        end
      end
      // Setup ADDIU k sits in EX in cycle k + 3
      if (!random_step && cycles >= 3 && cycles < 10) begin
        check_count++;
        if (o_alu_result !== exp_alu[cycles-3]) begin
          error_count++;
          $display("Error at %0t: ALU result %h for instruction %0d, expected %h",
                   $time, o_alu_result, cycles - 3, exp_alu[cycles-3]);
        end
      end
      pc_prev = o_pc;
      if (!o_halt && cycles >= 6 * prog_len + 20 + low_cycles) begin
        timed_out = 1'b1;
        error_count++;
        $display("timeout: halt never asserted");
      end
    end
  endtask

  task automatic check_halt_hold();
    logic [31:0] pc_hold;
    @(posedge i_clk);
    i_step <= 1'b1;
    @(negedge i_clk);
    pc_hold = o_pc;
    repeat (10) begin
      @(posedge i_clk);
      @(negedge i_clk);
      check_count++;
      if (o_halt !== 1'b1 || o_pc !== pc_hold) begin
        error_count++;
        $display("Error at %0t: after halt o_halt=%b o_pc=%h, expected 1 and %h",
                 $time, o_halt, o_pc, pc_hold);
      end
    end
  endtask

  task automatic check_state();
    for (int r = 1; r < 8; r++) begin
      @(posedge i_clk);
      i_dbg_reg <= 5'(r);
      @(negedge i_clk);
      check_count++;
      if (o_dbg_reg_data !== exp_regs[r]) begin
        error_count++;
        $display("Error at %0t: r%0d is %h, expected %h", $time, r, o_dbg_reg_data,
                 exp_regs[r]);
      end
    end
    for (int w = 0; w < DMEM_WORDS; w++) begin
      if (mem_written[w]) begin
        @(posedge i_clk);
        i_dbg_addr <= 32'(w * 4);
        @(negedge i_clk);
        check_count++;
        if (o_dbg_mem_data !== exp_mem[w]) begin
          error_count++;
          $display("Error at %0t: mem word %0d is %h, expected %h", $time, w,
                   o_dbg_mem_data, exp_mem[w]);
        end
      end
    end
  endtask

  task automatic run_test(input bit random_step);
    run_model();
    load_program();
    apply_reset();
    run_program(random_step);
    if (!timed_out) begin
      check_halt_hold();
      check_state();
    end
  endtask

  initial begin
    i_rst_n     = 1'b0;
    i_step      = 1'b0;
    i_imem_we   = 1'b0;
    i_imem_addr = '0;
    i_imem_data = '0;
    i_dbg_reg   = '0;
    i_dbg_addr  = '0;
    error_count = 0;
    check_count = 0;
    timed_out   = 1'b0;
    apply_reset();
    for (int t = 0; t < 5 && !timed_out; t++) begin
      build_alu_program(30);
      run_test(1'b0);
    end
    for (int t = 0; t < 4 && !timed_out; t++) begin
      build_mem_program(40);
      run_test(1'b0);
    end
    for (int t = 0; t < 6 && !timed_out; t++) begin
      build_branch_program(4);
      run_test(1'b0);
    end
    // Same kind of program with i_step dropping at random
    for (int t = 0; t < 3 && !timed_out; t++) begin
      build_mem_program(30);
      run_test(1'b1);
    end
    $display("Checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

//--- mips_pipeline.f
+incdir+.
mips_pkg.sv
mips_fetch.sv
mips_decode.sv
mips_execute.sv
mips_result.sv
mips_pipeline.sv
mips_pipeline_tb.sv
